/* Bender.yml */
package:
  name: flight_controller

sources:
  - source/flight_pkg.sv
  - source/us_tick.sv
  - source/rc_pulse_capture.sv
  - source/angle_controller.sv
  - source/motor_mixer.sv
  - source/esc_pwm.sv
  - source/flight_controller.sv
  - target: test
    files:
      - verif/flight_controller_tb.sv

/* all.f */
source/flight_pkg.sv
source/us_tick.sv
source/rc_pulse_capture.sv
source/angle_controller.sv
source/motor_mixer.sv
source/esc_pwm.sv
source/flight_controller.sv
verif/flight_controller_tb.sv

/* source/angle_controller.sv */
`timescale 1ns/1ps

module angle_controller (
	input  logic sys_clk,
	input  logic resetn,
	input  logic attitude_valid,
	input  flight_pkg::stick_t throttle_stick,
	input  flight_pkg::stick_t yaw_stick,
	input  flight_pkg::stick_t roll_stick,
	input  flight_pkg::stick_t pitch_stick,
	input  flight_pkg::angle_t roll_actual,
	input  flight_pkg::angle_t pitch_actual,
	output flight_pkg::rate_t throttle_rate,
	output flight_pkg::rate_t yaw_rate,
	output flight_pkg::rate_t roll_rate,
	output flight_pkg::rate_t pitch_rate,
	output logic ac_complete,
	output logic ac_active
);

	flight_pkg::ac_state_e state;
	flight_pkg::angle_t roll_act_q; // Attitude captured on strobe
	flight_pkg::angle_t pitch_act_q;
	flight_pkg::stick_t axis_stick; // Operands of shared axis path
	flight_pkg::angle_t axis_actual;
	flight_pkg::angle_err_t axis_err;
	flight_pkg::angle_err_t axis_scaled;
	flight_pkg::rate_t axis_rate;

	// One subtract/shift/saturate path steered by state
	assign axis_stick = (state == flight_pkg::AC_ROLL) ? roll_stick : pitch_stick;
	assign axis_actual = (state == flight_pkg::AC_ROLL) ? roll_act_q : pitch_act_q;

	always_comb begin
		// Stick offset is the target angle of +-8 deg at full stick
		axis_err = flight_pkg::angle_err_t'($signed({1'b0, axis_stick}))
			- flight_pkg::angle_err_t'(flight_pkg::STICK_CENTER)
			- flight_pkg::angle_err_t'(axis_actual);
		axis_scaled = axis_err >>> flight_pkg::ANGLE_KP_SHIFT; // Proportional gain
		if (axis_scaled > flight_pkg::angle_err_t'(flight_pkg::RATE_LIMIT))
			axis_rate = flight_pkg::rate_t'(flight_pkg::RATE_LIMIT);
		else if (axis_scaled < -flight_pkg::angle_err_t'(flight_pkg::RATE_LIMIT))
			axis_rate = -flight_pkg::rate_t'(flight_pkg::RATE_LIMIT);
		else
			axis_rate = flight_pkg::rate_t'(axis_scaled);
	end

	// Only an idle controller accepts new attitude
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			roll_act_q <= '0;
			pitch_act_q <= '0;
		end else if (state == flight_pkg::AC_IDLE && attitude_valid) begin
			roll_act_q <= roll_actual;
			pitch_act_q <= pitch_actual;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state <= flight_pkg::AC_IDLE;
			ac_complete <= 1'b0;
			ac_active <= 1'b0;
			throttle_rate <= '0;
			yaw_rate <= '0;
			roll_rate <= '0;
			pitch_rate <= '0;
		end else begin
			case (state)
				flight_pkg::AC_IDLE: begin
					if (attitude_valid) begin
						state <= flight_pkg::AC_ROLL;
						ac_active <= 1'b1;
					end
				end
				flight_pkg::AC_ROLL: begin
					roll_rate <= axis_rate;
					throttle_rate <= flight_pkg::rate_t'(throttle_stick)
						<< flight_pkg::THROTTLE_GAIN_SHIFT; // Throttle feeds straight through
					yaw_rate <= (flight_pkg::rate_t'(yaw_stick)
						- flight_pkg::rate_t'(flight_pkg::STICK_CENTER))
						<<< flight_pkg::YAW_GAIN_SHIFT; // Yaw is a rate stick without angle loop
					state <= flight_pkg::AC_PITCH;
				end
				flight_pkg::AC_PITCH: begin
					pitch_rate <= axis_rate;
					ac_complete <= 1'b1; // Rates all valid next cycle
					state <= flight_pkg::AC_DONE;
				end
				flight_pkg::AC_DONE: begin
					ac_complete <= 1'b0;
					ac_active <= 1'b0;
					state <= flight_pkg::AC_IDLE;
				end
				default: state <= flight_pkg::AC_IDLE;
			endcase
		end
	end

	a_complete_single: assert property (@(posedge sys_clk) disable iff (!resetn)
		ac_complete |=> !ac_complete)
		else $error("ac_complete held longer than one cycle");

	a_rate_bound: assert property (@(posedge sys_clk) disable iff (!resetn)
		roll_rate <= flight_pkg::RATE_LIMIT && roll_rate >= -flight_pkg::RATE_LIMIT
		&& pitch_rate <= flight_pkg::RATE_LIMIT && pitch_rate >= -flight_pkg::RATE_LIMIT)
		else $error("axis rate outside RATE_LIMIT");

endmodule

/* source/esc_pwm.sv */
`timescale 1ns/1ps

module esc_pwm (
	input  logic sys_clk,
	input  logic resetn,
	input  logic us_pulse,
	input  flight_pkg::motor_rate_t motor_rate,
	output logic pwm_out
);

	flight_pkg::us_count_t frame_us; // Position in ESC frame
	flight_pkg::us_count_t next_us;
	flight_pkg::us_count_t high_us; // Pulse width for this frame
	flight_pkg::motor_rate_t rate_q; // Rate frozen at frame start
	logic frame_end;

	assign frame_end = (frame_us == flight_pkg::us_count_t'(flight_pkg::PWM_PERIOD_US - 1));
	assign next_us = frame_us + 1'b1;
	assign high_us = flight_pkg::us_count_t'(flight_pkg::PWM_BASE_US)
		+ flight_pkg::us_count_t'(rate_q); // 1000 to 2000 us

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			// First microsecond after reset opens a frame
			frame_us <= flight_pkg::us_count_t'(flight_pkg::PWM_PERIOD_US - 1);
			rate_q <= '0;
			pwm_out <= 1'b0;
		end else if (us_pulse) begin
			if (frame_end) begin
				frame_us <= '0;
				rate_q <= motor_rate; // Mid-frame changes wait for here
				pwm_out <= 1'b1;
			end else begin
				frame_us <= next_us;
				pwm_out <= (next_us < high_us);
			end
		end
	end

	// Mixer range must hold at every frame this channel latches
	a_rate_latched: assert property (@(posedge sys_clk) disable iff (!resetn)
		rate_q <= flight_pkg::MOTOR_MAX)
		else $error("ESC latched a rate above MOTOR_MAX");

endmodule

/* source/flight_controller.sv */
`timescale 1ns/1ps

module flight_controller (
	input  logic sys_clk,
	input  logic resetn,
	input  logic throttle_pwm,
	input  logic yaw_pwm,
	input  logic roll_pwm,
	input  logic pitch_pwm,
	input  logic debug_throttle_n,
	input  logic attitude_valid,
	input  flight_pkg::angle_t roll_actual,
	input  flight_pkg::angle_t pitch_actual,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm,
	output logic [7:0] led_data_out
);

	logic us_pulse;
	logic ac_complete;

	// Receiver sticks
	flight_pkg::stick_t throttle_val;
	flight_pkg::stick_t yaw_val;
	flight_pkg::stick_t roll_val;
	flight_pkg::stick_t pitch_val;

	// Controller commands
	flight_pkg::rate_t throttle_rate;
	flight_pkg::rate_t yaw_rate;
	flight_pkg::rate_t roll_rate;
	flight_pkg::rate_t pitch_rate;

	// Mixed motor commands
	flight_pkg::motor_rate_t motor_1_rate;
	flight_pkg::motor_rate_t motor_2_rate;
	flight_pkg::motor_rate_t motor_3_rate;
	flight_pkg::motor_rate_t motor_4_rate;

	us_tick u_us_tick (.sys_clk, .resetn, .us_pulse);

	rc_pulse_capture u_rc_throttle (.sys_clk, .resetn, .us_pulse,
		.rc_in(throttle_pwm), .stick_val(throttle_val));
	rc_pulse_capture u_rc_yaw (.sys_clk, .resetn, .us_pulse,
		.rc_in(yaw_pwm), .stick_val(yaw_val));
	rc_pulse_capture u_rc_roll (.sys_clk, .resetn, .us_pulse,
		.rc_in(roll_pwm), .stick_val(roll_val));
	rc_pulse_capture u_rc_pitch (.sys_clk, .resetn, .us_pulse,
		.rc_in(pitch_pwm), .stick_val(pitch_val));

	angle_controller u_angle_controller (
		.sys_clk, .resetn, .attitude_valid,
		.throttle_stick(throttle_val), .yaw_stick(yaw_val),
		.roll_stick(roll_val), .pitch_stick(pitch_val),
		.roll_actual, .pitch_actual,
		.throttle_rate, .yaw_rate, .roll_rate, .pitch_rate,
		.ac_complete, .ac_active()
	);

	motor_mixer u_motor_mixer (
		.sys_clk, .resetn, .ac_complete,
		.throttle_rate, .yaw_rate, .roll_rate, .pitch_rate,
		.motor_1_rate, .motor_2_rate, .motor_3_rate, .motor_4_rate
	);

	esc_pwm u_esc_1 (.sys_clk, .resetn, .us_pulse,
		.motor_rate(motor_1_rate), .pwm_out(motor_1_pwm));
	esc_pwm u_esc_2 (.sys_clk, .resetn, .us_pulse,
		.motor_rate(motor_2_rate), .pwm_out(motor_2_pwm));
	esc_pwm u_esc_3 (.sys_clk, .resetn, .us_pulse,
		.motor_rate(motor_3_rate), .pwm_out(motor_3_pwm));
	esc_pwm u_esc_4 (.sys_clk, .resetn, .us_pulse,
		.motor_rate(motor_4_rate), .pwm_out(motor_4_pwm));

	// Board LEDs are active low
	always_ff @(posedge sys_clk) begin
		if (!resetn)
			led_data_out <= flight_pkg::LED_RESET_PATTERN;
		else if (!debug_throttle_n)
			led_data_out <= ~throttle_val; // Raw throttle stick
		else
			led_data_out <= motor_1_rate[9:2]; // Top 8 bits of motor 1 command
	end

endmodule

/* source/flight_pkg.sv */
package flight_pkg;

	typedef logic [7:0] stick_t; // Receiver stick value, 0 to 255
	typedef logic signed [15:0] angle_t; // 16 LSB per degree
	typedef logic signed [15:0] rate_t; // Controller rate command
	typedef logic [9:0] motor_rate_t; // Motor command, 0 to MOTOR_MAX
	typedef logic [11:0] us_count_t; // Microsecond counts up to 4095

	typedef logic signed [17:0] angle_err_t; // Target minus actual, no overflow
	typedef logic signed [17:0] mix_sum_t; // Sum of four rate terms

	// Timing
	localparam int SYS_CLK_PER_US = 10; // 10 MHz sys_clk
	localparam int RC_MIN_US = 1000; // Stick value 0
	localparam int RC_SPAN_US = 1020; // Full stick travel, 4 us per LSB
	localparam int RC_TIMEOUT_US = 4000; // Width counter stops here
	localparam int PWM_PERIOD_US = 2500; // ESC frame, 400 Hz
	localparam int PWM_BASE_US = 1000; // ESC pulse at motor rate 0

	// Stick and controller gains
	localparam int STICK_CENTER = 128; // Neutral stick
	localparam int THROTTLE_GAIN_SHIFT = 2; // Throttle x4
	localparam int YAW_GAIN_SHIFT = 1; // Yaw offset x2
	localparam int ANGLE_KP_SHIFT = 1; // Angle error / 2
	localparam int RATE_LIMIT = 511; // Axis rate magnitude limit

	localparam int MOTOR_MAX = 1000; // Top of motor range

	localparam logic [7:0] LED_RESET_PATTERN = 8'hAA; // Alternating LEDs in reset

	// Angle controller sequence, one axis per state
	typedef enum logic [1:0] {
		AC_IDLE, // Wait for attitude strobe
		AC_ROLL, // Roll axis plus throttle and yaw
		AC_PITCH, // Pitch axis
		AC_DONE // Completion strobe
	} ac_state_e;

endpackage

/* source/motor_mixer.sv */
`timescale 1ns/1ps

module motor_mixer (
	input  logic sys_clk,
	input  logic resetn,
	input  logic ac_complete,
	input  flight_pkg::rate_t throttle_rate,
	input  flight_pkg::rate_t yaw_rate,
	input  flight_pkg::rate_t roll_rate,
	input  flight_pkg::rate_t pitch_rate,
	output flight_pkg::motor_rate_t motor_1_rate,
	output flight_pkg::motor_rate_t motor_2_rate,
	output flight_pkg::motor_rate_t motor_3_rate,
	output flight_pkg::motor_rate_t motor_4_rate
);

	flight_pkg::mix_sum_t t_w; // Sign-extended rate terms
	flight_pkg::mix_sum_t p_w;
	flight_pkg::mix_sum_t r_w;
	flight_pkg::mix_sum_t y_w;
	flight_pkg::mix_sum_t sum_1;
	flight_pkg::mix_sum_t sum_2;
	flight_pkg::mix_sum_t sum_3;
	flight_pkg::mix_sum_t sum_4;

	// Saturate a mixed sum into the motor range
	function automatic flight_pkg::motor_rate_t clamp_motor(input flight_pkg::mix_sum_t sum);
		if (sum < 0)
			return '0; // Motor cannot run backwards
		else if (sum > flight_pkg::mix_sum_t'(flight_pkg::MOTOR_MAX))
			return flight_pkg::motor_rate_t'(flight_pkg::MOTOR_MAX);
		else
			return flight_pkg::motor_rate_t'(sum);
	endfunction

	assign t_w = flight_pkg::mix_sum_t'(throttle_rate);
	assign p_w = flight_pkg::mix_sum_t'(pitch_rate);
	assign r_w = flight_pkg::mix_sum_t'(roll_rate);
	assign y_w = flight_pkg::mix_sum_t'(yaw_rate);

	// Quad-X layout
	assign sum_1 = t_w + p_w + r_w - y_w; // Front, CW
	assign sum_2 = t_w + p_w - r_w + y_w; // Front, CCW
	assign sum_3 = t_w - p_w - r_w - y_w; // Rear, CW
	assign sum_4 = t_w - p_w + r_w + y_w; // Rear, CCW

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_1_rate <= '0;
			motor_2_rate <= '0;
			motor_3_rate <= '0;
			motor_4_rate <= '0;
		end else if (ac_complete) begin // New set of rates from controller
			motor_1_rate <= clamp_motor(sum_1);
			motor_2_rate <= clamp_motor(sum_2);
			motor_3_rate <= clamp_motor(sum_3);
			motor_4_rate <= clamp_motor(sum_4);
		end
	end

	a_motor_range: assert property (@(posedge sys_clk) disable iff (!resetn)
		motor_1_rate <= flight_pkg::MOTOR_MAX && motor_2_rate <= flight_pkg::MOTOR_MAX
		&& motor_3_rate <= flight_pkg::MOTOR_MAX && motor_4_rate <= flight_pkg::MOTOR_MAX)
		else $error("motor rate above MOTOR_MAX");

endmodule

/* source/rc_pulse_capture.sv */
`timescale 1ns/1ps

module rc_pulse_capture (
	input  logic sys_clk,
	input  logic resetn,
	input  logic us_pulse,
	input  logic rc_in,
	output flight_pkg::stick_t stick_val
);

	logic rc_meta; // First synchronizer stage
	logic rc_sync; // Second synchronizer stage
	logic rc_prev; // Delayed copy for edge detect
	logic rc_fall; // Synchronized falling edge
	flight_pkg::us_count_t width_us; // High time so far
	flight_pkg::us_count_t offset_us; // Width above RC_MIN_US, clamped
	flight_pkg::stick_t stick_next;

	assign rc_fall = rc_prev & ~rc_sync;

	// Map measured width onto the stick range
	always_comb begin
		if (width_us <= flight_pkg::us_count_t'(flight_pkg::RC_MIN_US))
			offset_us = '0; // Short pulse reads as zero stick
		else if (width_us >= flight_pkg::us_count_t'(flight_pkg::RC_MIN_US + flight_pkg::RC_SPAN_US))
			offset_us = flight_pkg::us_count_t'(flight_pkg::RC_SPAN_US); // Clamp long pulse
		else
			offset_us = width_us - flight_pkg::us_count_t'(flight_pkg::RC_MIN_US);
		stick_next = flight_pkg::stick_t'(offset_us >> 2); // 4 us per stick LSB
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			rc_meta <= 1'b0;
			rc_sync <= 1'b0;
			rc_prev <= 1'b0;
			width_us <= '0;
			stick_val <= '0;
		end else begin
			rc_meta <= rc_in;
			rc_sync <= rc_meta;
			rc_prev <= rc_sync;
			if (!rc_sync)
				width_us <= '0; // Restart while input is low
			else if (us_pulse && width_us != flight_pkg::us_count_t'(flight_pkg::RC_TIMEOUT_US))
				width_us <= width_us + 1'b1; // Saturates at timeout
			// Load on falling edge, hold when pulses stop
			if (rc_fall)
				stick_val <= stick_next;
		end
	end

endmodule

/* source/us_tick.sv */
`timescale 1ns/1ps

module us_tick (
	input  logic sys_clk,
	input  logic resetn,
	output logic us_pulse
);

	logic [$clog2(flight_pkg::SYS_CLK_PER_US)-1:0] div_cnt; // Cycles left in this microsecond

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			div_cnt <= ($bits(div_cnt))'(flight_pkg::SYS_CLK_PER_US - 1);
			us_pulse <= 1'b0;
		end else if (div_cnt == '0) begin
			div_cnt <= ($bits(div_cnt))'(flight_pkg::SYS_CLK_PER_US - 1); // Reload
			us_pulse <= 1'b1; // One cycle enable
		end else begin
			div_cnt <= div_cnt - 1'b1;
			us_pulse <= 1'b0;
		end
	end

	// Enable must stay a single cycle wide for every timed block
	a_pulse_single: assert property (@(posedge sys_clk) disable iff (!resetn)
		us_pulse |=> !us_pulse)
		else $error("us_pulse high on two consecutive cycles");

endmodule

/* verif/flight_controller_tb.sv */
`timescale 1ns/1ps

module flight_controller_tb;

	localparam int CLK_PER_US = 10; // 100 ns clock
	localparam int FRAME_WAIT = 60000; // Two ESC frames and margin in cycles

	logic sys_clk;
	logic resetn;
	logic throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm;
	logic debug_throttle_n;
	logic attitude_valid;
	flight_pkg::angle_t roll_actual;
	flight_pkg::angle_t pitch_actual;
	logic motor_1_pwm, motor_2_pwm, motor_3_pwm, motor_4_pwm;
	logic [7:0] led_data_out;
	logic [3:0] motor_pwm;

	integer seed = 32'hf0a9b2fe;
	int errors = 0;
	int err_base = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int thr_w, yaw_w, roll_w, pitch_w; // Last pulse widths sent per channel
	int rand_w;
	int led_motor_exp; // Top 8 bits of motor 1 rate
	int exp_led; // Expected LED value
	int exp_width [4]; // Expected motor high times in us
	logic led_check; // LED assertion window
	logic reset_check; // Reset assertion window
	logic width_arm; // Pulses starting now get checked

	// Motor pulse monitor state
	logic [3:0] pwm_q = '0;
	logic [3:0] armed_start = '0;
	logic [3:0] width_new = '0;
	int high_cnt [4] = '{0, 0, 0, 0};
	int width_meas [4] = '{0, 0, 0, 0};
	int armed_falls [4] = '{0, 0, 0, 0};

	assign motor_pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

	flight_controller dut0 (
		.sys_clk, .resetn,
		.throttle_pwm, .yaw_pwm, .roll_pwm, .pitch_pwm,
		.debug_throttle_n, .attitude_valid,
		.roll_actual, .pitch_actual,
		.motor_1_pwm, .motor_2_pwm, .motor_3_pwm, .motor_4_pwm,
		.led_data_out
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	function automatic int clamp_int(input int v, input int lo, input int hi);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v;
	endfunction

	function automatic bit within_tol(input int a, input int b, input int tol);
		return (a - b <= tol) && (b - a <= tol);
	endfunction

	// Receiver width to stick value with 4 us per step above 1000 us
	function automatic int stick_of(input int width_us);
		return clamp_int(width_us - flight_pkg::RC_MIN_US, 0, flight_pkg::RC_SPAN_US) / 4;
	endfunction

	function automatic int axis_rate(input int stick, input int actual);
		int err;
		err = (stick - flight_pkg::STICK_CENTER - actual) >>> flight_pkg::ANGLE_KP_SHIFT;
		return clamp_int(err, -flight_pkg::RATE_LIMIT, flight_pkg::RATE_LIMIT);
	endfunction

	// Sampled on the falling edge away from DUT updates
	always @(negedge sys_clk) begin
		for (int m = 0; m < 4; m++) begin
			width_new[m] <= 1'b0;
			if (motor_pwm[m]) begin
				if (!pwm_q[m]) begin
					high_cnt[m] <= 1; // Rising edge
					armed_start[m] <= width_arm;
				end else
					high_cnt[m] <= high_cnt[m] + 1;
			end else if (pwm_q[m]) begin
				width_meas[m] <= (high_cnt[m] + CLK_PER_US / 2) / CLK_PER_US;
				if (armed_start[m]) begin
					width_new[m] <= 1'b1; // Complete pulse of a checked frame
					armed_falls[m] <= armed_falls[m] + 1;
				end
			end
			pwm_q[m] <= motor_pwm[m];
		end
	end

	a_reset_state: assert property (@(posedge sys_clk) reset_check |->
		led_data_out == flight_pkg::LED_RESET_PATTERN && motor_pwm == 4'b0000)
		else begin
			$display("FAIL %0t: reset state wrong, led %h motors %b",
				$time, led_data_out, motor_pwm);
			errors++;
		end

	a_led_value: assert property (@(posedge sys_clk) led_check |->
		within_tol(int'(led_data_out), exp_led, 1))
		else begin
			$display("FAIL %0t: led %0d, expected %0d", $time, led_data_out, exp_led);
			errors++;
		end

	for (genvar g = 0; g < 4; g++) begin : g_width_check
		a_motor_width: assert property (@(posedge sys_clk) width_new[g] |->
			within_tol(width_meas[g], exp_width[g], 1))
			else begin
				$display("FAIL %0t: motor %0d high %0d us, expected %0d us",
					$time, g + 1, width_meas[g], exp_width[g]);
				errors++;
			end
	end

	task automatic drive_rc(input int ch, input logic level);
		case (ch)
			0: throttle_pwm <= level;
			1: yaw_pwm <= level;
			2: roll_pwm <= level;
			default: pitch_pwm <= level;
		endcase
	endtask

	task automatic send_rc_pulse(input int ch, input int width_us);
		@(posedge sys_clk);
		drive_rc(ch, 1'b1);
		repeat (width_us * CLK_PER_US) @(posedge sys_clk);
		drive_rc(ch, 1'b0);
		repeat (4 * CLK_PER_US) @(posedge sys_clk); // Gap while the stick loads
	endtask

	task automatic set_sticks(input int t, input int y, input int r, input int p);
		thr_w = t;
		yaw_w = y;
		roll_w = r;
		pitch_w = p;
		send_rc_pulse(0, t);
		send_rc_pulse(1, y);
		send_rc_pulse(2, r);
		send_rc_pulse(3, p);
	endtask

	task automatic strobe_attitude(input int roll, input int pitch);
		@(posedge sys_clk);
		roll_actual <= 16'(roll);
		pitch_actual <= 16'(pitch);
		attitude_valid <= 1'b1;
		@(posedge sys_clk);
		attitude_valid <= 1'b0;
	endtask

	// Quad-X mix of the current sticks and given attitude
	task automatic expect_motors(input int roll, input int pitch);
		int t, y, r, p;
		int sum [4];
		t = stick_of(thr_w) << flight_pkg::THROTTLE_GAIN_SHIFT;
		y = (stick_of(yaw_w) - flight_pkg::STICK_CENTER) * (1 << flight_pkg::YAW_GAIN_SHIFT);
		r = axis_rate(stick_of(roll_w), roll);
		p = axis_rate(stick_of(pitch_w), pitch);
		sum[0] = t + p + r - y;
		sum[1] = t + p - r + y;
		sum[2] = t - p - r - y;
		sum[3] = t - p + r + y;
		for (int m = 0; m < 4; m++)
			exp_width[m] = flight_pkg::PWM_BASE_US + clamp_int(sum[m], 0, flight_pkg::MOTOR_MAX);
		led_motor_exp = clamp_int(sum[0], 0, flight_pkg::MOTOR_MAX) >> 2;
	endtask

	// Checks one whole frame that starts after the mixer update
	task automatic check_next_frame();
		int base [4];
		int cycles;
		bit done;
		@(posedge sys_clk);
		for (int m = 0; m < 4; m++)
			base[m] = armed_falls[m];
		width_arm <= 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < FRAME_WAIT) begin
			@(posedge sys_clk);
			cycles++;
			done = 1'b1;
			for (int m = 0; m < 4; m++)
				if (armed_falls[m] == base[m])
					done = 1'b0;
		end
		width_arm <= 1'b0;
		if (!done) begin
			$display("Timeout: not all motors finished a pulse within %0d cycles", FRAME_WAIT);
			errors++;
		end
		repeat (2) @(posedge sys_clk); // Let the last width assertion finish
	endtask

	task automatic await_motors(input int roll, input int pitch);
		expect_motors(roll, pitch);
		repeat (8) @(posedge sys_clk); // Controller and mixer latency
		check_next_frame();
	endtask

	task automatic check_led(input int value);
		exp_led <= value;
		led_check <= 1'b1;
		repeat (4) @(posedge sys_clk);
		led_check <= 1'b0;
		@(posedge sys_clk);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == err_base)
			$display("Test %0d %s: ok", tests_run, name);
		else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_base);
		end
		err_base = errors;
	endtask

	initial begin
		resetn = 1'b0;
		throttle_pwm = 1'b0;
		yaw_pwm = 1'b0;
		roll_pwm = 1'b0;
		pitch_pwm = 1'b0;
		debug_throttle_n = 1'b1;
		attitude_valid = 1'b0;
		roll_actual = '0;
		pitch_actual = '0;
		led_check = 1'b0;
		reset_check = 1'b0;
		width_arm = 1'b0;
		exp_led = 0;
		thr_w = flight_pkg::RC_MIN_US;
		yaw_w = flight_pkg::RC_MIN_US;
		roll_w = flight_pkg::RC_MIN_US;
		pitch_w = flight_pkg::RC_MIN_US;

		@(posedge sys_clk);
		reset_check <= 1'b1; // Outputs already reset
		repeat (4) @(posedge sys_clk);
		resetn <= 1'b1;
		reset_check <= 1'b0;
		@(posedge sys_clk);
		finish_test("reset");

		debug_throttle_n <= 1'b0; // LEDs show inverted throttle
		rand_w = 1000 + int'($unsigned($random(seed)) % 1021);
		send_rc_pulse(0, 1500);
		check_led(255 - stick_of(1500));
		send_rc_pulse(0, 1000);
		check_led(255 - stick_of(1000));
		send_rc_pulse(0, 2020);
		check_led(255 - stick_of(2020));
		send_rc_pulse(0, rand_w);
		check_led(255 - stick_of(rand_w));
		finish_test("receiver capture");

		debug_throttle_n <= 1'b1;
		set_sticks(1500, 1512, 1512, 1512);
		strobe_attitude(0, 0);
		await_motors(0, 0);
		check_led(led_motor_exp);
		finish_test("neutral hover");

		strobe_attitude(64, -32);
		await_motors(64, -32);
		finish_test("roll and pitch correction");

		set_sticks(2020, 1512, 1512, 1512);
		strobe_attitude(-2000, 2000);
		await_motors(-2000, 2000); // Mix runs past both ends
		finish_test("saturation");

		thr_w = 1500;
		send_rc_pulse(0, 1500);
		strobe_attitude(0, 0);
		strobe_attitude(-2000, 2000); // Arrives while controller is busy
		await_motors(0, 0);
		finish_test("strobe while busy");

		$display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
